//--- src/soc_pkg.sv
// SoC shared definitions
`default_nettype none

package soc_pkg;

  ////////////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////////////

  // Byte address, data word and byte enables
  localparam int unsigned ADR_W = 14;
  localparam int unsigned DAT_W = 32;
  localparam int unsigned BEN_W = DAT_W / 8;

  // Memory fills the lower half of the space, 8 KiB of words
  localparam int unsigned MEM_ADR_W = 11;

  // Address bits that split the space
  localparam int unsigned ADR_BIT_PER  = 13;
  localparam int unsigned ADR_BIT_UART = 6;

  ////////////////////////////////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned GPIO_W = 32;

  // Clock cycles per UART bit, kept short for simulation
  localparam int unsigned BAUD_DIV = 8;
  localparam int unsigned BAUD_CW  = $clog2(BAUD_DIV);

  // Vector types with a meaning
  typedef logic [ADR_W-1:0]  adr_t;
  typedef logic [DAT_W-1:0]  dat_t;
  typedef logic [BEN_W-1:0]  ben_t;
  typedef logic [GPIO_W-1:0] gpio_t;

  // GPIO registers, bit 6 clear
  localparam adr_t REG_GPIO_OUT  = 14'h0000;
  localparam adr_t REG_GPIO_ENA  = 14'h0004;
  localparam adr_t REG_GPIO_IN   = 14'h0008;

  // UART registers, bit 6 set
  localparam adr_t REG_UART_TX   = 14'h0040;
  localparam adr_t REG_UART_STAT = 14'h0044;
  localparam adr_t REG_UART_RX   = 14'h0048;

  // Decoder targets
  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_GPIO,
    TGT_UART
  } tgt_sel_t;

  // Transmit FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_t;

endpackage : soc_pkg

`default_nettype wire

//--- src/tcb_dec.sv
// System bus address decoder
`timescale 1ns/1ps
`default_nettype none

module tcb_dec
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // Master side
  input  logic     bus_vld,
  input  logic     bus_wen,
  input  adr_t     bus_adr,
  input  ben_t     bus_ben,
  input  dat_t     bus_wdt,
  output dat_t     bus_rdt,
  output logic     bus_err,
  output logic     bus_rdy,
  // Memory target
  output logic     mem_vld,
  input  dat_t     mem_rdt,
  input  logic     mem_err,
  input  logic     mem_rdy,
  // GPIO target
  output logic     gpio_vld,
  input  dat_t     gpio_rdt,
  input  logic     gpio_err,
  input  logic     gpio_rdy,
  // UART target
  output logic     uart_vld,
  input  dat_t     uart_rdt,
  input  logic     uart_err,
  input  logic     uart_rdy
);

  tgt_sel_t tgt;
  tgt_sel_t rsp_sel;
  logic     rsp_vld;
  logic     rsp_rd;
  dat_t     sel_rdt;
  logic     sel_err;

  // Upper half is peripherals, bit 6 splits GPIO from UART
  always_comb begin
    if (!bus_adr[ADR_BIT_PER]) tgt = TGT_MEM;
    else if (!bus_adr[ADR_BIT_UART]) tgt = TGT_GPIO;
    else tgt = TGT_UART;
  end

  // Only the addressed target sees a request
  assign mem_vld  = bus_vld & (tgt == TGT_MEM);
  assign gpio_vld = bus_vld & (tgt == TGT_GPIO);
  assign uart_vld = bus_vld & (tgt == TGT_UART);

  // Handshake follows the current target
  always_comb begin
    case (tgt)
      TGT_GPIO: bus_rdy = gpio_rdy;
      TGT_UART: bus_rdy = uart_rdy;
      default:  bus_rdy = mem_rdy;
    endcase
  end

  // Remember who answers next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_sel <= TGT_MEM;
      rsp_vld <= 1'b0;
      rsp_rd  <= 1'b0;
    end else begin
      rsp_vld <= bus_vld & bus_rdy;
      rsp_rd  <= bus_vld & bus_rdy & ~bus_wen;
      if (bus_vld && bus_rdy) rsp_sel <= tgt;
    end
  end

  // Response steering
  always_comb begin
    case (rsp_sel)
      TGT_GPIO: begin
        sel_rdt = gpio_rdt;
        sel_err = gpio_err;
      end
      TGT_UART: begin
        sel_rdt = uart_rdt;
        sel_err = uart_err;
      end
      default: begin
        sel_rdt = mem_rdt;
        sel_err = mem_err;
      end
    endcase
  end

  // Data only after reads, err only in the response cycle
  assign bus_rdt = rsp_rd ? sel_rdt : '0;
  assign bus_err = rsp_vld & sel_err;

  a_one_target: assert property (@(posedge clk) disable iff (reset)
    $onehot0({mem_vld, gpio_vld, uart_vld}));

endmodule : tcb_dec

`default_nettype wire

//--- src/soc_mem.sv
// Data memory with byte lanes
`timescale 1ns/1ps
`default_nettype none

module soc_mem
  import soc_pkg::*;
(
  input  logic clk,
  input  logic vld,
  input  logic wen,
  input  adr_t adr,
  input  ben_t ben,
  input  dat_t wdt,
  output dat_t rdt,
  output logic err,
  output logic rdy
);

  localparam int unsigned DEPTH = 2 ** MEM_ADR_W;

  // Word storage
  dat_t mem [DEPTH];

  // Byte address to word index
  logic [MEM_ADR_W-1:0] idx;

  assign idx = adr[MEM_ADR_W+1:2];

  ////////////////////////////////////////////////////////////////////
  // Single port access
  ////////////////////////////////////////////////////////////////////

  // Read first, lanes written where enabled
  always_ff @(posedge clk) begin
    if (vld) begin
      if (wen) begin
        for (int b = 0; b < BEN_W; b++) begin
          if (ben[b]) mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
      rdt <= mem[idx];
    end
  end

  // Never stalls, never faults
  assign err = 1'b0;
  assign rdy = 1'b1;

endmodule : soc_mem

`default_nettype wire

//--- src/tcb_gpio.sv
// GPIO controller
`timescale 1ns/1ps
`default_nettype none

module tcb_gpio
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  vld,
  input  logic  wen,
  input  adr_t  adr,
  input  ben_t  ben,
  input  dat_t  wdt,
  output dat_t  rdt,
  output logic  err,
  output logic  rdy,
  // Pins
  output gpio_t gpio_o,
  output gpio_t gpio_e,
  input  gpio_t gpio_i
);

  logic  is_out;
  logic  is_ena;
  logic  is_in;
  gpio_t gpio_s1;
  gpio_t gpio_in;

  // Word offset within the window
  assign is_out = adr[6:2] == REG_GPIO_OUT[6:2];
  assign is_ena = adr[6:2] == REG_GPIO_ENA[6:2];
  assign is_in  = adr[6:2] == REG_GPIO_IN[6:2];

  // Output and enable, byte lanes
  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (vld && wen) begin
      for (int b = 0; b < BEN_W; b++) begin
        if (ben[b] && is_out) gpio_o[8*b +: 8] <= wdt[8*b +: 8];
        if (ben[b] && is_ena) gpio_e[8*b +: 8] <= wdt[8*b +: 8];
      end
    end
  end

  // Two flop synchronizer, second stage is the input register
  always_ff @(posedge clk) begin
    gpio_s1 <= gpio_i;
    gpio_in <= gpio_s1;
  end

  // Read mux, unmapped offsets read zero
  always_ff @(posedge clk) begin
    if (vld && !wen) begin
      if (is_out) rdt <= gpio_o;
      else if (is_ena) rdt <= gpio_e;
      else if (is_in) rdt <= gpio_in;
      else rdt <= '0;
    end
  end

  // Input register is read only
  always_ff @(posedge clk) begin
    if (reset) err <= 1'b0;
    else err <= vld & wen & is_in;
  end

  assign rdy = 1'b1;

endmodule : tcb_gpio

`default_nettype wire

//--- src/tcb_uart.sv
// UART controller
`timescale 1ns/1ps
`default_nettype none

module tcb_uart
  import soc_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic vld,
  input  logic wen,
  input  adr_t adr,
  input  dat_t wdt,
  output dat_t rdt,
  output logic err,
  output logic rdy,
  // Serial line
  output logic uart_txd,
  input  logic uart_rxd
);

  logic                is_tx;
  logic                is_stat;
  logic                is_rx;
  logic                tx_wr;
  logic                rx_rd;
  // Transmitter
  uart_tx_state_t      tx_state;
  logic [BAUD_CW-1:0]  tx_cnt;
  logic [2:0]          tx_bit;
  logic [7:0]          tx_sh;
  logic                tx_busy;
  // Receiver
  logic                rx_s1;
  logic                rx_s2;
  logic                rx_act;
  logic [BAUD_CW-1:0]  rx_cnt;
  logic [3:0]          rx_bit;
  logic [7:0]          rx_sh;
  logic [7:0]          rx_dat;
  logic                rx_vld;

  assign is_tx   = adr[6:2] == REG_UART_TX[6:2];
  assign is_stat = adr[6:2] == REG_UART_STAT[6:2];
  assign is_rx   = adr[6:2] == REG_UART_RX[6:2];
  assign tx_wr   = vld & wen & is_tx;
  assign rx_rd   = vld & ~wen & is_rx;
  assign tx_busy = tx_state != TX_IDLE;

  ////////////////////////////////////////////////////////////////////
  // Transmitter
  ////////////////////////////////////////////////////////////////////

  // Start, 8 bits LSB first, stop; writes while busy are lost
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_state <= TX_IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      uart_txd <= 1'b1;
    end else begin
      case (tx_state)
        TX_IDLE: if (tx_wr) begin
          tx_sh    <= wdt[7:0];
          tx_cnt   <= '0;
          uart_txd <= 1'b0;
          tx_state <= TX_START;
        end
        TX_START: if (tx_cnt == BAUD_CW'(BAUD_DIV-1)) begin
          tx_cnt   <= '0;
          tx_bit   <= '0;
          uart_txd <= tx_sh[0];
          tx_sh    <= tx_sh >> 1;
          tx_state <= TX_DATA;
        end else tx_cnt <= tx_cnt + 1'b1;
        TX_DATA: if (tx_cnt == BAUD_CW'(BAUD_DIV-1)) begin
          tx_cnt <= '0;
          if (tx_bit == 3'd7) begin
            uart_txd <= 1'b1;
            tx_state <= TX_STOP;
          end else begin
            uart_txd <= tx_sh[0];
            tx_sh    <= tx_sh >> 1;
            tx_bit   <= tx_bit + 1'b1;
          end
        end else tx_cnt <= tx_cnt + 1'b1;
        default: if (tx_cnt == BAUD_CW'(BAUD_DIV-1)) begin
          tx_cnt   <= '0;
          tx_state <= TX_IDLE;
        end else tx_cnt <= tx_cnt + 1'b1;
      endcase
    end
  end

  a_tx_idle_high: assert property (@(posedge clk) disable iff (reset)
    tx_state == TX_IDLE |-> uart_txd);

  ////////////////////////////////////////////////////////////////////
  // Receiver
  ////////////////////////////////////////////////////////////////////

  // Bit 0 is start, 1 to 8 data, 9 stop; samples at mid bit
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_s1  <= 1'b1;
      rx_s2  <= 1'b1;
      rx_act <= 1'b0;
      rx_cnt <= '0;
      rx_bit <= '0;
      rx_vld <= 1'b0;
    end else begin
      rx_s1 <= uart_rxd;
      rx_s2 <= rx_s1;
      if (rx_rd) rx_vld <= 1'b0;
      if (!rx_act) begin
        if (!rx_s2) begin
          rx_act <= 1'b1;
          rx_bit <= '0;
          rx_cnt <= BAUD_CW'(BAUD_DIV/2 - 1);
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_cnt <= BAUD_CW'(BAUD_DIV-1);
        rx_bit <= rx_bit + 1'b1;
        if (rx_bit == 4'd0) begin
          // Glitch, not a real start bit
          if (rx_s2) rx_act <= 1'b0;
        end else if (rx_bit == 4'd9) begin
          rx_act <= 1'b0;
          if (rx_s2) rx_vld <= 1'b1;
        end
      end
    end
  end

  // Shift and byte capture
  always_ff @(posedge clk) begin
    if (rx_act && rx_cnt == '0) begin
      if (rx_bit >= 4'd1 && rx_bit <= 4'd8) rx_sh <= {rx_s2, rx_sh[7:1]};
      if (rx_bit == 4'd9 && rx_s2) rx_dat <= rx_sh;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Register access
  ////////////////////////////////////////////////////////////////////

  // TX reads back zero
  always_ff @(posedge clk) begin
    if (vld && !wen) begin
      if (is_stat) rdt <= dat_t'({rx_vld, tx_busy});
      else if (is_rx) rdt <= dat_t'(rx_dat);
      else rdt <= '0;
    end
  end

  // Status and RX are read only
  always_ff @(posedge clk) begin
    if (reset) err <= 1'b0;
    else err <= vld & wen & (is_stat | is_rx);
  end

  assign rdy = 1'b1;

endmodule : tcb_uart

`default_nettype wire

//--- src/soc_top.sv
// SoC peripheral top level
`timescale 1ns/1ps
`default_nettype none

module soc_top
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  // System bus from the core
  input  logic  bus_vld,
  input  logic  bus_wen,
  input  adr_t  bus_adr,
  input  ben_t  bus_ben,
  input  dat_t  bus_wdt,
  output dat_t  bus_rdt,
  output logic  bus_err,
  output logic  bus_rdy,
  // GPIO pins
  output gpio_t gpio_o,
  output gpio_t gpio_e,
  input  gpio_t gpio_i,
  // UART pins
  output logic  uart_txd,
  input  logic  uart_rxd
);

  // Per target handshake and response
  logic mem_vld;
  dat_t mem_rdt;
  logic mem_err;
  logic mem_rdy;
  logic gpio_vld;
  dat_t gpio_rdt;
  logic gpio_err;
  logic gpio_rdy;
  logic uart_vld;
  dat_t uart_rdt;
  logic uart_err;
  logic uart_rdy;

  ////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////

  tcb_dec tcb_dec_inst (
    .clk, .reset,
    .bus_vld, .bus_wen, .bus_adr, .bus_ben, .bus_wdt,
    .bus_rdt, .bus_err, .bus_rdy,
    .mem_vld, .mem_rdt, .mem_err, .mem_rdy,
    .gpio_vld, .gpio_rdt, .gpio_err, .gpio_rdy,
    .uart_vld, .uart_rdt, .uart_err, .uart_rdy
  );

  ////////////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////////////

  // Shared request fields go straight to each target
  soc_mem soc_mem_inst (
    .clk (clk), .vld (mem_vld), .wen (bus_wen), .adr (bus_adr),
    .ben (bus_ben), .wdt (bus_wdt),
    .rdt (mem_rdt), .err (mem_err), .rdy (mem_rdy)
  );

  tcb_gpio tcb_gpio_inst (
    .clk (clk), .reset (reset), .vld (gpio_vld), .wen (bus_wen),
    .adr (bus_adr), .ben (bus_ben), .wdt (bus_wdt),
    .rdt (gpio_rdt), .err (gpio_err), .rdy (gpio_rdy),
    .gpio_o (gpio_o), .gpio_e (gpio_e), .gpio_i (gpio_i)
  );

  // No byte enables, registers are word wide
  tcb_uart tcb_uart_inst (
    .clk (clk), .reset (reset), .vld (uart_vld), .wen (bus_wen),
    .adr (bus_adr), .wdt (bus_wdt),
    .rdt (uart_rdt), .err (uart_err), .rdy (uart_rdy),
    .uart_txd (uart_txd), .uart_rxd (uart_rxd)
  );

endmodule : soc_top

`default_nettype wire

//--- dv/soc_tb.sv
// SoC peripheral testbench
`timescale 1ns/1ps
`default_nettype none

module soc_tb
  import soc_pkg::*;
();

  localparam int   HALF_PERIOD     = 10;
  localparam int   RESET_CYCLES    = 16;
  localparam int   RDY_LIMIT       = 16;
  localparam int   POLL_LIMIT      = int'(30 * BAUD_DIV);
  localparam int   WATCHDOG_CYCLES = 20000;
  localparam adr_t PER_BASE        = 14'h2000;

  logic  clk;
  logic  reset;
  logic  bus_vld;
  logic  bus_wen;
  adr_t  bus_adr;
  ben_t  bus_ben;
  dat_t  bus_wdt;
  dat_t  bus_rdt;
  logic  bus_err;
  logic  bus_rdy;
  gpio_t gpio_o;
  gpio_t gpio_e;
  gpio_t gpio_i;
  logic  uart_txd;
  logic  uart_rxd;

  // Expected response, set with the request
  logic  req_chk;
  dat_t  req_rdt;
  logic  req_err;
  // Same, moved to the response cycle
  logic  rsp_vld;
  logic  rsp_chk;
  dat_t  rsp_rdt;
  logic  rsp_err;

  logic [31:0] lfsr_state = 32'h57727518;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_errs = 0;

  // Reference state
  dat_t                 mem_model [2**MEM_ADR_W];
  logic [MEM_ADR_W-1:0] used_q [$];
  gpio_t                gpio_out_m;
  gpio_t                gpio_ena_m;
  gpio_t                gpio_in_v;
  logic [7:0]           last_byte;

  soc_top soc_top_inst (
    .clk, .reset,
    .bus_vld, .bus_wen, .bus_adr, .bus_ben, .bus_wdt,
    .bus_rdt, .bus_err, .bus_rdy,
    .gpio_o, .gpio_e, .gpio_i,
    .uart_txd, .uart_rxd
  );

  // Serial loopback
  assign uart_rxd = uart_txd;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // Response checking
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      rsp_vld <= 1'b0;
      rsp_chk <= 1'b0;
    end else begin
      rsp_vld <= bus_vld & bus_rdy;
      rsp_chk <= bus_vld & bus_rdy & req_chk;
    end
    rsp_rdt <= req_rdt;
    rsp_err <= req_err;
  end

  a_rdy_high: assert property (@(posedge clk) bus_rdy)
    else begin
      errors++;
      $display("MISMATCH at %0t: bus_rdy got %b expected 1", $time, $sampled(bus_rdy));
    end

  // Err only in the response cycle
  a_err_val: assert property (@(posedge clk) disable iff (reset)
    bus_err == (rsp_vld & rsp_err))
    else begin
      errors++;
      $display("MISMATCH at %0t: bus_err got %b expected %b", $time,
               $sampled(bus_err), $sampled(rsp_vld & rsp_err));
    end

  // Read data exactly one cycle after the transfer
  a_rdt_val: assert property (@(posedge clk) disable iff (reset)
    rsp_chk |-> bus_rdt == rsp_rdt)
    else begin
      errors++;
      $display("MISMATCH at %0t: bus_rdt got %h expected %h", $time,
               $sampled(bus_rdt), $sampled(rsp_rdt));
    end

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic dat_t merge_lanes(input dat_t old, input dat_t wdt, input ben_t ben);
    dat_t r;
    r = old;
    for (int b = 0; b < BEN_W; b++) begin
      if (ben[b]) r[8*b +: 8] = wdt[8*b +: 8];
    end
    return r;
  endfunction

  function automatic adr_t mem_adr(input logic [MEM_ADR_W-1:0] idx);
    return adr_t'({1'b0, idx, 2'b00});
  endfunction

  task automatic check_val(input string name, input dat_t got, input dat_t exp);
    assert (got === exp)
      else begin
        errors++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
  endtask

  task automatic end_run();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic bus_xfer(input logic wen, input adr_t adr, input ben_t ben,
                          input dat_t wdt, input logic chk, input dat_t exp_rdt,
                          input logic exp_err, output dat_t rdt);
    int cnt;
    cnt = 0;
    bus_vld = 1'b1;
    bus_wen = wen;
    bus_adr = adr;
    bus_ben = ben;
    bus_wdt = wdt;
    req_chk = chk;
    req_rdt = exp_rdt;
    req_err = exp_err;
    // Transfer on the first rising edge with ready high
    do begin
      @(posedge clk);
      cnt++;
    end while (!bus_rdy && cnt < RDY_LIMIT);
    if (!bus_rdy) begin
      errors++;
      $display("Timeout: bus_rdy stayed low for %0d cycles", RDY_LIMIT);
      end_run();
    end else begin
      @(negedge clk);
      bus_vld = 1'b0;
      req_chk = 1'b0;
      req_err = 1'b0;
      rdt = bus_rdt;
    end
  endtask

  task automatic write_reg(input adr_t adr, input ben_t ben, input dat_t wdt,
                           input logic exp_err);
    dat_t ignored;
    bus_xfer(1'b1, adr, ben, wdt, 1'b0, '0, exp_err, ignored);
  endtask

  task automatic read_check(input adr_t adr, input dat_t exp);
    dat_t ignored;
    bus_xfer(1'b0, adr, '0, '0, 1'b1, exp, 1'b0, ignored);
  endtask

  task automatic read_raw(input adr_t adr, output dat_t rdt);
    bus_xfer(1'b0, adr, '0, '0, 1'b0, '0, 1'b0, rdt);
  endtask

  // Poll UART status until a flag reaches the level
  task automatic wait_status(input int bit_idx, input logic level, input string what);
    dat_t st;
    int   cnt;
    cnt = 0;
    read_raw(PER_BASE | REG_UART_STAT, st);
    while (st[bit_idx] !== level && cnt < POLL_LIMIT) begin
      read_raw(PER_BASE | REG_UART_STAT, st);
      cnt++;
    end
    if (st[bit_idx] !== level) begin
      errors++;
      $display("Timeout: UART %s not seen after %0d status reads", what, POLL_LIMIT);
      end_run();
    end
  endtask

  task automatic start_test();
    test_errs = errors;
  endtask

  task automatic end_test(input string name);
    // One more edge so the last response gets checked
    @(negedge clk);
    tests_run++;
    if (errors != test_errs) begin
      tests_failed++;
      $display("Test %s: FAILED, %0d errors", name, errors - test_errs);
    end else begin
      $display("Test %s: passed", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    start_test();
    check_val("gpio_o", gpio_o, '0);
    check_val("gpio_e", gpio_e, '0);
    check_val("uart_txd", dat_t'(uart_txd), 32'h1);
    check_val("bus_err", dat_t'(bus_err), '0);
    // Status flags clear
    read_check(PER_BASE | REG_UART_STAT, '0);
    end_test("reset state");
  endtask

  task automatic test_memory();
    logic [MEM_ADR_W-1:0] idx;
    ben_t                 ben;
    dat_t                 wdt;
    int                   k;
    start_test();
    // Full words first so no lane stays unknown
    for (int i = 0; i < 16; i++) begin
      idx = MEM_ADR_W'(rand_bits(MEM_ADR_W));
      wdt = rand_bits(DAT_W);
      write_reg(mem_adr(idx), 4'hf, wdt, 1'b0);
      mem_model[idx] = wdt;
      used_q.push_back(idx);
    end
    // Partial writes, some read straight back
    for (int i = 0; i < 32; i++) begin
      k = int'(rand_bits(8)) % used_q.size();
      idx = used_q[k];
      ben = BEN_W'(rand_bits(BEN_W));
      wdt = rand_bits(DAT_W);
      write_reg(mem_adr(idx), ben, wdt, 1'b0);
      mem_model[idx] = merge_lanes(mem_model[idx], wdt, ben);
      if (i % 4 == 0) read_check(mem_adr(idx), mem_model[idx]);
    end
    foreach (used_q[i]) begin
      read_check(mem_adr(used_q[i]), mem_model[used_q[i]]);
    end
    end_test("memory");
  endtask

  task automatic test_gpio();
    dat_t v;
    ben_t ben;
    start_test();
    v = rand_bits(DAT_W);
    write_reg(PER_BASE | REG_GPIO_OUT, 4'hf, v, 1'b0);
    gpio_out_m = v;
    check_val("gpio_o", gpio_o, gpio_out_m);
    v = rand_bits(DAT_W);
    write_reg(PER_BASE | REG_GPIO_ENA, 4'hf, v, 1'b0);
    gpio_ena_m = v;
    check_val("gpio_e", gpio_e, gpio_ena_m);
    // Byte lanes on the output register
    ben = BEN_W'(rand_bits(BEN_W));
    v = rand_bits(DAT_W);
    write_reg(PER_BASE | REG_GPIO_OUT, ben, v, 1'b0);
    gpio_out_m = merge_lanes(gpio_out_m, v, ben);
    check_val("gpio_o", gpio_o, gpio_out_m);
    read_check(PER_BASE | REG_GPIO_OUT, gpio_out_m);
    read_check(PER_BASE | REG_GPIO_ENA, gpio_ena_m);
    // Pins held three cycles, past the synchronizer
    gpio_i = gpio_t'(rand_bits(GPIO_W));
    gpio_in_v = gpio_i;
    repeat (3) @(negedge clk);
    read_check(PER_BASE | REG_GPIO_IN, gpio_in_v);
    end_test("gpio");
  endtask

  task automatic test_uart();
    logic [7:0] tx_byte;
    dat_t       st;
    start_test();
    for (int k = 0; k < 4; k++) begin
      tx_byte = 8'(rand_bits(8));
      write_reg(PER_BASE | REG_UART_TX, 4'hf, dat_t'(tx_byte), 1'b0);
      // Start bit right after the write
      check_val("uart_txd", dat_t'(uart_txd), '0);
      // Busy set, nothing received yet
      read_check(PER_BASE | REG_UART_STAT, 32'h1);
      if (k == 1) write_reg(PER_BASE | REG_UART_TX, 4'hf, dat_t'(~tx_byte), 1'b0);
      wait_status(1, 1'b1, "receive valid");
      read_check(PER_BASE | REG_UART_RX, dat_t'(tx_byte));
      read_raw(PER_BASE | REG_UART_STAT, st);
      check_val("rx valid flag", dat_t'(st[1]), '0);
      wait_status(0, 1'b0, "transmitter idle");
      last_byte = tx_byte;
    end
    end_test("uart loopback");
  endtask

  task automatic test_bus_errors();
    start_test();
    write_reg(PER_BASE | REG_GPIO_IN, 4'hf, rand_bits(DAT_W), 1'b1);
    check_val("gpio_o", gpio_o, gpio_out_m);
    check_val("gpio_e", gpio_e, gpio_ena_m);
    read_check(PER_BASE | REG_GPIO_IN, gpio_in_v);
    read_check(PER_BASE | REG_GPIO_OUT, gpio_out_m);
    read_check(PER_BASE | REG_GPIO_ENA, gpio_ena_m);
    // Status stays clear, line stays idle
    write_reg(PER_BASE | REG_UART_STAT, 4'hf, 32'h3, 1'b1);
    read_check(PER_BASE | REG_UART_STAT, '0);
    check_val("uart_txd", dat_t'(uart_txd), 32'h1);
    write_reg(PER_BASE | REG_UART_RX, 4'hf, dat_t'(~last_byte), 1'b1);
    read_check(PER_BASE | REG_UART_RX, dat_t'(last_byte));
    read_check(PER_BASE | REG_UART_STAT, '0);
    end_test("bus errors");
  endtask

  ////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    bus_vld = 1'b0;
    bus_wen = 1'b0;
    bus_adr = '0;
    bus_ben = '0;
    bus_wdt = '0;
    gpio_i = '0;
    req_chk = 1'b0;
    req_rdt = '0;
    req_err = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_memory();
    test_gpio();
    test_uart();
    test_bus_errors();
    end_run();
  end

  // Hard stop
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    errors++;
    $display("Simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
    end_run();
  end

endmodule : soc_tb

`default_nettype wire

//--- tb.f
src/soc_pkg.sv
src/tcb_dec.sv
src/soc_mem.sv
src/tcb_gpio.sv
src/tcb_uart.sv
src/soc_top.sv
dv/soc_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= soc_tb
FILELIST   ?= tb.f

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass line shows up in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
